// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= pipe_core_tb
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
logic/rv_pkg.sv
logic/hazard_unit.sv
logic/decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/pipe_core.sv
verif/pipe_core_sva.sv
verif/pipe_core_tb.sv

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::alu_op_e op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    output logic [31:0]     result_o,
    output logic            zero_o
);
    import rv_pkg::*;

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            // Signed compare
            ALU_SLT: result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            default: result_o = '0;
        endcase
    end

    // BEQ takes the branch when the difference is zero
    assign zero_o = (result_o == 32'd0);

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic [31:0]  instr_i,
    output rv_pkg::ctrl_t ctrl_o,
    output logic [4:0]   rs1_o,
    output logic [4:0]   rs2_o,
    output logic [4:0]   rd_o,
    output logic [31:0]  imm_o
);
    import rv_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i_type;
    logic [31:0] imm_s_type;
    logic [31:0] imm_b_type;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    // Sign-extended immediates, B-type is a byte offset with bit 0 zero
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        // Anything not matched below stays a no-op
        ctrl_o = '0;
        imm_o  = imm_i_type;
        case (opcode)
            OP: begin
                ctrl_o.reg_wr = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
                    default:              ctrl_o = '0;
                endcase
            end
            OP_IMM: begin
                // ADDI only
                if (funct3 == 3'b000) begin
                    ctrl_o.reg_wr      = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                end
            end
            LOAD: begin
                // LW only, address is rs1 + imm
                if (funct3 == 3'b010) begin
                    ctrl_o.reg_wr      = 1'b1;
                    ctrl_o.mem_rd      = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                end
            end
            STORE: begin
                imm_o = imm_s_type;
                if (funct3 == 3'b010) begin
                    ctrl_o.mem_wr      = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                end
            end
            BRANCH: begin
                imm_o = imm_b_type;
                // BEQ compares by subtraction and zero flag
                if (funct3 == 3'b000) begin
                    ctrl_o.branch = 1'b1;
                    ctrl_o.alu_op = ALU_SUB;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    // Decode-stage sources, used for load-use detection
    input  logic [4:0]       rd_addr1_d_i,
    input  logic [4:0]       rd_addr2_d_i,
    // Execute-stage destination and load flag
    input  logic [4:0]       wr_addr_e_i,
    input  logic             mem_rd_e_i,
    // Execute-stage sources
    input  logic [4:0]       rd_addr1_e_i,
    input  logic [4:0]       rd_addr2_e_i,
    // Older instructions that may still write a register
    input  logic [4:0]       wr_addr_m_i,
    input  logic [4:0]       wr_addr_w_i,
    input  logic             reg_wr_en_m_i,
    input  logic             reg_wr_en_w_i,
    // Taken branch resolved in execute
    input  logic             pc_src_i,
    output rv_pkg::fwd_sel_e forward_a_e_o,
    output rv_pkg::fwd_sel_e forward_b_e_o,
    output logic             stall_o,
    output logic             flush_o
);
    import rv_pkg::*;

    logic load_hit_d;

    // Operand A, memory stage is younger so it wins over writeback
    always_comb begin
        if (reg_wr_en_m_i && (wr_addr_m_i != 5'd0) && (wr_addr_m_i == rd_addr1_e_i)) begin
            forward_a_e_o = FWD_MEM;
        end else if (reg_wr_en_w_i && (wr_addr_w_i != 5'd0) && (wr_addr_w_i == rd_addr1_e_i)) begin
            forward_a_e_o = FWD_WB;
        end else begin
            forward_a_e_o = FWD_NONE;
        end
    end

    // Operand B, same priority
    always_comb begin
        if (reg_wr_en_m_i && (wr_addr_m_i != 5'd0) && (wr_addr_m_i == rd_addr2_e_i)) begin
            forward_b_e_o = FWD_MEM;
        end else if (reg_wr_en_w_i && (wr_addr_w_i != 5'd0) && (wr_addr_w_i == rd_addr2_e_i)) begin
            forward_b_e_o = FWD_WB;
        end else begin
            forward_b_e_o = FWD_NONE;
        end
    end

    // Load result only exists after memory, so a consumer in decode waits one cycle
    assign load_hit_d = (wr_addr_e_i != 5'd0) &&
                        ((wr_addr_e_i == rd_addr1_d_i) || (wr_addr_e_i == rd_addr2_d_i));
    assign stall_o    = mem_rd_e_i && load_hit_d;

    // Taken branch squashes fetch and decode
    assign flush_o    = pc_src_i;

endmodule

`default_nettype wire

// ==== logic/pipe_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_core (
    input  logic        clk_i,
    input  logic        reset_i,
    // Instruction memory, combinational read
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_data_i,
    // Data memory, word access
    output logic [31:0] dmem_addr_o,
    output logic [31:0] dmem_wdata_o,
    output logic        dmem_we_o,
    input  logic [31:0] dmem_rdata_i,
    // Retire port
    output logic        wb_valid_o,
    output logic [4:0]  wb_addr_o,
    output logic [31:0] wb_data_o
);
    import rv_pkg::*;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] alu_res;
        logic [31:0] wdata;
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] alu_res;
        logic [31:0] rdata;
        logic [4:0]  rd;
    } mem_wb_t;

    logic [31:0] pc;
    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;

    // Decode outputs
    ctrl_t       ctrl_d;
    logic [4:0]  rs1_d;
    logic [4:0]  rs2_d;
    logic [4:0]  rd_d;
    logic [31:0] imm_d;
    logic [31:0] rd1_d;
    logic [31:0] rd2_d;

    // Execute
    fwd_sel_e    forward_a_e;
    fwd_sel_e    forward_b_e;
    logic [31:0] src_a_e;
    logic [31:0] src_b_e;
    logic [31:0] alu_res_e;
    logic        zero_e;
    logic        pc_src_e;
    logic [31:0] target_e;

    logic        stall;
    logic        flush;
    logic [31:0] result_w;

    // Fetch, PC holds on stall and jumps on a taken branch
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc <= 32'd0;
        end else if (flush) begin
            pc <= target_e;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr_o = pc;

    // Zero instruction word decodes as a no-op, so clearing makes a bubble
    always_ff @(posedge clk_i) begin
        if (reset_i || flush) begin
            if_id <= '0;
        end else if (!stall) begin
            if_id <= '{pc: pc, instr: imem_data_i};
        end
    end

    decoder u_decoder (
        .instr_i (if_id.instr),
        .ctrl_o  (ctrl_d),
        .rs1_o   (rs1_d),
        .rs2_o   (rs2_d),
        .rd_o    (rd_d),
        .imm_o   (imm_d)
    );

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rs1_i   (rs1_d),
        .rs2_i   (rs2_d),
        .we_i    (mem_wb.ctrl.reg_wr),
        .wa_i    (mem_wb.rd),
        .wd_i    (result_w),
        .rd1_o   (rd1_d),
        .rd2_o   (rd2_d)
    );

    // Bubble into execute on stall or flush
    always_ff @(posedge clk_i) begin
        if (reset_i || flush || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{ctrl: ctrl_d, pc: if_id.pc, rd1: rd1_d, rd2: rd2_d,
                       imm: imm_d, rs1: rs1_d, rs2: rs2_d, rd: rd_d};
        end
    end

    hazard_unit u_hazard_unit (
        .rd_addr1_d_i  (rs1_d),
        .rd_addr2_d_i  (rs2_d),
        .wr_addr_e_i   (id_ex.rd),
        .mem_rd_e_i    (id_ex.ctrl.mem_rd),
        .rd_addr1_e_i  (id_ex.rs1),
        .rd_addr2_e_i  (id_ex.rs2),
        .wr_addr_m_i   (ex_mem.rd),
        .wr_addr_w_i   (mem_wb.rd),
        .reg_wr_en_m_i (ex_mem.ctrl.reg_wr),
        .reg_wr_en_w_i (mem_wb.ctrl.reg_wr),
        .pc_src_i      (pc_src_e),
        .forward_a_e_o (forward_a_e),
        .forward_b_e_o (forward_b_e),
        .stall_o       (stall),
        .flush_o       (flush)
    );

    // Forwarding muxes
    always_comb begin
        case (forward_a_e)
            FWD_MEM: src_a_e = ex_mem.alu_res;
            FWD_WB:  src_a_e = result_w;
            default: src_a_e = id_ex.rd1;
        endcase
        case (forward_b_e)
            FWD_MEM: src_b_e = ex_mem.alu_res;
            FWD_WB:  src_b_e = result_w;
            default: src_b_e = id_ex.rd2;
        endcase
    end

    alu u_alu (
        .op_i     (id_ex.ctrl.alu_op),
        .a_i      (src_a_e),
        .b_i      (id_ex.ctrl.alu_src_imm ? id_ex.imm : src_b_e),
        .result_o (alu_res_e),
        .zero_o   (zero_e)
    );

    // BEQ resolves here
    assign pc_src_e = id_ex.ctrl.branch && zero_e;
    assign target_e = id_ex.pc + id_ex.imm;

    // Forwarded rs2 doubles as store data
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{ctrl: id_ex.ctrl, alu_res: alu_res_e, wdata: src_b_e, rd: id_ex.rd};
        end
    end

    assign dmem_addr_o  = ex_mem.alu_res;
    assign dmem_wdata_o = ex_mem.wdata;
    assign dmem_we_o    = ex_mem.ctrl.mem_wr;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{ctrl: ex_mem.ctrl, alu_res: ex_mem.alu_res,
                        rdata: dmem_rdata_i, rd: ex_mem.rd};
        end
    end

    // Writeback picks load data or ALU result
    assign result_w   = mem_wb.ctrl.mem_rd ? mem_wb.rdata : mem_wb.alu_res;

    // x0 writes are not reported
    assign wb_valid_o = mem_wb.ctrl.reg_wr && (mem_wb.rd != 5'd0);
    assign wb_addr_o  = mem_wb.rd;
    assign wb_data_o  = result_w;

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic        we_i,
    input  logic [4:0]  wa_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [31:0] regs [32];

    // Write at the edge, x0 is never stored
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != 5'd0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    // Same-cycle write passes straight through to decode
    assign rd1_o = (rs1_i == 5'd0) ? 32'd0 :
                   (we_i && (wa_i == rs1_i)) ? wd_i : regs[rs1_i];
    assign rd2_o = (rs2_i == 5'd0) ? 32'd0 :
                   (we_i && (wa_i == rs2_i)) ? wd_i : regs[rs2_i];

endmodule

`default_nettype wire

// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations, encoding 0 is ADD so an all-zero control word is harmless
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_e;

    // Decoded control, all zero is a no-op
    typedef struct packed {
        logic    reg_wr;
        logic    mem_rd;
        logic    mem_wr;
        logic    branch;
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== verif/pipe_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_core_sva (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  logic             wb_valid_i,
    input  logic             dmem_we_i,
    // Memory-stage destination
    input  logic [4:0]       wr_addr_m_i,
    input  rv_pkg::fwd_sel_e forward_a_i,
    input  rv_pkg::fwd_sel_e forward_b_i
);
    import rv_pkg::*;

    // A load and a branch never share execute
    stall_flush_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(stall_i && flush_i))
        else $error("stall and flush asserted in the same cycle");

    // Stage registers are bubbles after a reset edge
    retire_quiet_in_reset: assert property (@(posedge clk_i)
        (reset_i && $past(reset_i)) |-> !wb_valid_i)
        else $error("retire strobe high during reset");

    // The flushing branch itself moves into memory and never stores
    no_store_after_flush: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |=> !dmem_we_i)
        else $error("store strobe high in the cycle after a flush");

    // x0 is never a forwarding source
    no_fwd_from_x0: assert property (@(posedge clk_i) disable iff (reset_i)
        (wr_addr_m_i == 5'd0) |-> ((forward_a_i != FWD_MEM) && (forward_b_i != FWD_MEM)))
        else $error("memory-stage forward selected for destination x0");

endmodule

bind pipe_core pipe_core_sva u_sva (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .stall_i     (stall),
    .flush_i     (flush),
    .wb_valid_i  (wb_valid_o),
    .dmem_we_i   (dmem_we_o),
    .wr_addr_m_i (ex_mem.rd),
    .forward_a_i (forward_a_e),
    .forward_b_i (forward_b_e)
);

`default_nettype wire

// ==== verif/pipe_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_core_tb;
    import rv_pkg::*;

    localparam int          PROG_LEN        = 64;
    localparam int          PROG_BYTES      = PROG_LEN * 4;
    localparam int          DMEM_WORDS      = 256;
    localparam int          RESET_CYCLES    = 16;
    // Fetch to retire is four edges, one more for a stall
    localparam int          DRAIN_CYCLES    = 6;
    localparam int          WATCHDOG_CYCLES = PROG_LEN * 4 + RESET_CYCLES + 64;
    localparam logic [31:0] SEED            = 32'ha4ddece6;
    localparam logic [31:0] LFSR_TAPS       = 32'hd0000001;
    localparam logic [31:0] NOP_INSTR       = 32'h00000013;

    // Expected register write, kept in program order
    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
    } retire_t;

    // Store seen in the memory stage
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] model_mem [DMEM_WORDS];
    logic [31:0] lfsr_state;
    retire_t     exp_q [$];
    retire_t     head;
    store_t      pending;
    int          mismatch_count;
    int          other_errors;
    int          retire_count;

    pipe_core dut_i (
        .clk_i        (clk),
        .reset_i      (reset),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata),
        .wb_valid_o   (wb_valid),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data)
    );

    // Past the program the core only sees no-ops
    assign imem_data  = (imem_addr < PROG_BYTES) ? prog[imem_addr[7:2]] : NOP_INSTR;
    // Word-addressed data memory, upper address bits ignored
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // sel picks ADD, SUB, AND, OR, XOR, else SLT
    function automatic logic [31:0] encode_r(input logic [2:0] sel, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [4:0] rd);
        logic [6:0] funct7;
        logic [2:0] funct3;
        funct7 = 7'b0000000;
        case (sel)
            3'd0: funct3 = 3'b000;
            3'd1: begin
                funct7 = 7'b0100000;
                funct3 = 3'b000;
            end
            3'd2: funct3 = 3'b111;
            3'd3: funct3 = 3'b110;
            3'd4: funct3 = 3'b100;
            default: funct3 = 3'b010;
        endcase
        return {funct7, rs2, rs1, funct3, rd, OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] funct3, input logic [4:0] rd,
                                             input opcode_e op);
        return {imm, rs1, funct3, rd, op};
    endfunction

    // SW only
    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    // BEQ only, imm is a byte offset
    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], BRANCH};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Random program over x0-x7 so hazards are frequent
    task automatic gen_program();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  base;
        logic [11:0] offset;
        logic [31:0] br_off;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind   = 3'(take_bits(3));
            rd     = 5'(take_bits(3));
            rs1    = 5'(take_bits(3));
            rs2    = 5'(take_bits(3));
            // Mostly x0 based, so stores and loads hit the same few words
            base   = (take_bits(2) == 32'd0) ? rs1 : 5'd0;
            offset = {6'd0, 4'(take_bits(4)), 2'b00};
            case (kind)
                3'd0, 3'd1: prog[i] = encode_r(3'(take_bits(3)), rs2, rs1, rd);
                3'd2, 3'd3: prog[i] = encode_i(12'(take_bits(12)), rs1, 3'b000, rd, OP_IMM);
                3'd4, 3'd7: prog[i] = encode_i(offset, base, 3'b010, rd, LOAD);
                3'd5:       prog[i] = encode_s(offset, rs2, base);
                default: begin
                    // Skip two to five words forward, equal sources half the time
                    br_off  = (take_bits(2) + 32'd2) << 2;
                    prog[i] = encode_b(br_off[12:0], (take_bits(1) != 32'd0) ? rs1 : rs2, rs1);
                end
            endcase
        end
    endtask

    // Sequential ISA model, queues every write to a nonzero register
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic        wr;
        retire_t     w;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        pc = 32'd0;
        while (pc < PROG_BYTES) begin
            instr   = prog[pc[7:2]];
            rd      = instr[11:7];
            f3      = instr[14:12];
            f7      = instr[31:25];
            a       = regs[instr[19:15]];
            b       = regs[instr[24:20]];
            wr      = 1'b0;
            val     = 32'd0;
            next_pc = pc + 32'd4;
            case (instr[6:0])
                OP: begin
                    wr = 1'b1;
                    case ({f7, f3})
                        {7'b0000000, 3'b000}: val = a + b;
                        {7'b0100000, 3'b000}: val = a - b;
                        {7'b0000000, 3'b111}: val = a & b;
                        {7'b0000000, 3'b110}: val = a | b;
                        {7'b0000000, 3'b100}: val = a ^ b;
                        {7'b0000000, 3'b010}: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:              wr  = 1'b0;
                    endcase
                end
                OP_IMM: begin
                    if (f3 == 3'b000) begin
                        wr  = 1'b1;
                        val = a + {{20{instr[31]}}, instr[31:20]};
                    end
                end
                LOAD: begin
                    if (f3 == 3'b010) begin
                        addr = a + {{20{instr[31]}}, instr[31:20]};
                        wr   = 1'b1;
                        val  = model_mem[addr[9:2]];
                    end
                end
                STORE: begin
                    if (f3 == 3'b010) begin
                        addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                        model_mem[addr[9:2]] = b;
                    end
                end
                BRANCH: begin
                    if ((f3 == 3'b000) && (a == b)) begin
                        next_pc = pc + {{19{instr[31]}}, instr[31], instr[7],
                                        instr[30:25], instr[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            if (wr && (rd != 5'd0)) begin
                regs[rd] = val;
                w.addr   = rd;
                w.data   = val;
                exp_q.push_back(w);
            end
            pc = next_pc;
        end
    endtask

    // Latch the memory-stage store mid-cycle and write it just after the edge
    initial begin
        forever begin
            @(negedge clk);
            pending.we   = dmem_we && !reset;
            pending.addr = dmem_addr;
            pending.data = dmem_wdata;
            @(posedge clk);
            #1;
            if (pending.we) begin
                dmem[pending.addr[9:2]] = pending.data;
            end
        end
    end

    // Retire checker, sampled mid-cycle where the outputs are settled
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Error: x%0d retired but no register write was expected", wb_addr);
            end else begin
                head = exp_q.pop_front();
                check_value($sformatf("retire %0d addr", retire_count),
                            {27'd0, head.addr}, {27'd0, wb_addr});
                check_value($sformatf("retire %0d data", retire_count), head.data, wb_data);
                retire_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset          = 1'b1;
        mismatch_count = 0;
        other_errors   = 0;
        retire_count   = 0;
        lfsr_state     = SEED;
        gen_program();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]      = take_bits(32);
            model_mem[i] = dmem[i];
        end
        run_model();
        $display("Program of %0d instructions, %0d register writes expected",
                 PROG_LEN, exp_q.size());

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Fetch leaving the program means every instruction is in flight
        while (imem_addr < PROG_BYTES) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);

        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Error: %0d expected register writes never retired", exp_q.size());
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            check_value($sformatf("dmem word %0d", i), model_mem[i], dmem[i]);
        end

        $display("Retired %0d, mismatches %0d, other errors %0d",
                 retire_count, mismatch_count, other_errors);
        if ((mismatch_count == 0) && (other_errors == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
